// File: logic/mem_gate_pkg.sv
package mem_gate_pkg;

	// the stream is handled one 32-bit word at a time once the bytes are assembled
	localparam int word_w = 32;

	// local-bus address width, the low part of every command word
	localparam int addr_w = 24;

	// flag positions counted in the full command word, in network bit order
	localparam int rd_bit = 28;
	localparam int rep_bit = 29;

	// a repeat word carries its count in the low bits
	localparam int rep_w = 9;

	// sequence number and nonce lead every packet and are never decoded
	localparam int header_words = 2;

	// normal command word, eight control bits over the address
	typedef struct packed {
		logic [word_w-addr_w-1:0] ctl;
		logic [addr_w-1:0] addr;
	} ctl_addr_t;

	// repeat word, only the count below the spare bits matters
	typedef struct packed {
		logic [word_w-rep_w-1:0] spare;
		logic [rep_w-1:0] count;
	} repeat_t;

	// the same word is read as either view depending on the repeat flag
	typedef union packed {
		ctl_addr_t ctl_addr;
		repeat_t rpt;
	} cmd_word_t;

endpackage

// File: logic/local_bus_if.sv
`timescale 1ns/1ps

interface local_bus_if import mem_gate_pkg::*; ();

	logic [addr_w-1:0] addr;
	logic [word_w-1:0] data_out;
	logic [word_w-1:0] data_in;
	// single-cycle request pulse, addr and rd are stable around it
	logic strobe;
	// rd is a level that changes only when a new command is loaded
	logic rd;
	logic write;
	// marks the cycle where read data is expected on data_in
	logic rd_valid;

	// the sequencer owns the request side and the read marker pipe
	modport master (output addr, data_out, strobe, rd, write, rd_valid);

	// the register bank answers with data_in only
	modport target (input addr, data_out, strobe, rd, write, output data_in);

	// the reply side only needs the marker and the returned word
	modport capture (input rd_valid, data_in);

endinterface

// File: logic/packet_framer.sv
`timescale 1ns/1ps

module packet_framer import mem_gate_pkg::*; #(
	parameter int read_pipe_len = 3
) (
	input logic clk,
	input logic arst_n,
	input logic [7:0] idata,
	input logic raw_s,
	output cmd_word_t word,
	output logic word_tick,
	output logic [7:0] pdata
);

	// enough bits to count all header words before the body starts
	localparam int hdr_w = $clog2(header_words + 1);

	logic [word_w-1:0] isr;
	logic [1:0] c4;
	logic [hdr_w-1:0] hdr_cnt;
	logic body;
	logic [read_pipe_len:0][7:0] dly;
	logic last_byte;

	// the fourth byte of a word is on idata while c4 is 3
	assign last_byte = raw_s && (c4 == 2'd3);

	// word includes the byte arriving now, so it is complete on the tick cycle
	assign word = {isr[word_w-9:0], idata};
	assign word_tick = body && last_byte;
	assign pdata = dly[read_pipe_len];

	// plain byte shifter, its contents only matter on a tick
	always_ff @(posedge clk) begin
		isr <= {isr[word_w-9:0], idata};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			c4 <= '0;
			hdr_cnt <= '0;
			body <= 1'b0;
		end else begin
			c4 <= raw_s ? c4 + 2'd1 : 2'd0;
			// a gap in raw_s ends the packet, so the next one starts with its header
			if (!raw_s) begin
				hdr_cnt <= '0;
				body <= 1'b0;
			end else if (last_byte && !body) begin
				if (hdr_cnt == hdr_w'(header_words - 1))
					body <= 1'b1;
				hdr_cnt <= hdr_cnt + 1'b1;
			end
		end
	end

	// raw bytes wait here until the bus has had time to answer a read
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			dly <= '0;
		end else begin
			dly[0] <= idata;
			for (int i = 1; i <= read_pipe_len; i++)
				dly[i] <= dly[i-1];
		end
	end

endmodule

// File: logic/bus_sequencer.sv
`timescale 1ns/1ps

module bus_sequencer import mem_gate_pkg::*; #(
	parameter int read_pipe_len = 3,
	parameter bit enable_bursts = 1'b1
) (
	input logic clk,
	input logic arst_n,
	input cmd_word_t word,
	input logic word_tick,
	input logic raw_s,
	local_bus_if.master bus
);

	logic data_phase;
	logic [rep_w-1:0] rep_left;
	logic inc_addr;
	logic [addr_w-1:0] addr_r;
	logic rd_r;
	logic [word_w-1:0] data_r;
	logic strobe_r;
	logic [read_pipe_len-1:0] rd_mark;
	logic is_repeat;
	logic read_op;

	// a repeat word is only recognised in the command slot and when bursts are on
	assign is_repeat = enable_bursts && !data_phase && word.ctl_addr.ctl[rep_bit-addr_w];
	assign read_op = strobe_r && rd_r;

	assign bus.addr = addr_r;
	assign bus.data_out = data_r;
	assign bus.strobe = strobe_r;
	assign bus.rd = rd_r;
	assign bus.write = strobe_r && !rd_r;
	// the reply side captures data_in on exactly this cycle
	assign bus.rd_valid = rd_mark[read_pipe_len-1];

	// only the data slot needs to be captured, it is never cleared
	always_ff @(posedge clk) begin
		if (word_tick && data_phase)
			data_r <= word;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			data_phase <= 1'b0;
			rep_left <= '0;
			inc_addr <= 1'b0;
			addr_r <= '0;
			rd_r <= 1'b0;
			strobe_r <= 1'b0;
		end else begin
			// every data word produces one strobe on the following cycle
			strobe_r <= word_tick && data_phase;
			if (!raw_s) begin
				data_phase <= 1'b0;
				rep_left <= '0;
				inc_addr <= 1'b0;
			end else if (word_tick) begin
				inc_addr <= 1'b0;
				// the previous repeat has had its strobe, move on to the next address
				if (inc_addr)
					addr_r <= addr_r + 1'b1;
				if (is_repeat) begin
					// a count of n means n operations, so n-1 extra data words
					rep_left <= (word.rpt.count == '0) ? '0 : word.rpt.count - 1'b1;
				end else if (!data_phase) begin
					data_phase <= 1'b1;
					addr_r <= word.ctl_addr.addr;
					rd_r <= word.ctl_addr.ctl[rd_bit-addr_w];
				end else if (rep_left != '0) begin
					rep_left <= rep_left - 1'b1;
					inc_addr <= 1'b1;
				end else begin
					data_phase <= 1'b0;
				end
			end
		end
	end

	// one marker per read in flight, several can overlap on long pipes
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_mark <= '0;
		end else begin
			rd_mark[0] <= read_op;
			for (int i = 1; i < read_pipe_len; i++)
				rd_mark[i] <= rd_mark[i-1];
		end
	end

endmodule

// File: logic/reply_merger.sv
`timescale 1ns/1ps

module reply_merger import mem_gate_pkg::*; #(
	parameter int read_pipe_len = 3,
	parameter int n_lat = 12
) (
	input logic clk,
	input logic arst_n,
	input logic [7:0] pdata,
	local_bus_if.capture bus,
	output logic [7:0] odata
);

	// whatever latency is left after the framer delay and the 4-byte shifter
	localparam int fin_len = n_lat - read_pipe_len - 5;

	logic [word_w-1:0] osr;

	// read data lands over the echoed data field, aligned so its top byte goes out next
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			osr <= '0;
		else if (bus.rd_valid)
			osr <= bus.data_in;
		else
			osr <= {osr[word_w-9:0], pdata};
	end

	generate
		if (fin_len == 0) begin : g_no_fin
			// shifter output already has the full latency
			assign odata = osr[word_w-1 -: 8];
		end else begin : g_fin
			logic [fin_len-1:0][7:0] fin;

			always_ff @(posedge clk or negedge arst_n) begin
				if (!arst_n) begin
					fin <= '0;
				end else begin
					fin[0] <= osr[word_w-1 -: 8];
					for (int i = 1; i < fin_len; i++)
						fin[i] <= fin[i-1];
				end
			end

			assign odata = fin[fin_len-1];
		end
	endgenerate

endmodule

// File: logic/reg_bank.sv
`timescale 1ns/1ps

module reg_bank import mem_gate_pkg::*; #(
	parameter int read_pipe_len = 3
) (
	input logic clk,
	input logic arst_n,
	local_bus_if.target bus
);

	localparam int n_words = 16;
	localparam int idx_w = $clog2(n_words);

	logic [word_w-1:0] regs [n_words];
	logic [read_pipe_len-1:0][word_w-1:0] rd_pipe;
	logic [idx_w-1:0] idx;

	// higher address bits are ignored, so the bank repeats across the address space
	assign idx = bus.addr[idx_w-1:0];

	// last pipe stage lines up with rd_valid from the sequencer
	assign bus.data_in = rd_pipe[read_pipe_len-1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < n_words; i++)
				regs[i] <= '0;
		end else if (bus.write) begin
			// write lands at the end of its strobe cycle
			regs[idx] <= bus.data_out;
		end
	end

	// each stage advances every cycle, so back-to-back reads stay in order
	always_ff @(posedge clk) begin
		if (bus.strobe && bus.rd)
			rd_pipe[0] <= regs[idx];
		for (int i = 1; i < read_pipe_len; i++)
			rd_pipe[i] <= rd_pipe[i-1];
	end

endmodule

// File: logic/mem_gate_top.sv
`timescale 1ns/1ps

module mem_gate_top import mem_gate_pkg::*; #(
	parameter int read_pipe_len = 3,
	parameter int n_lat = 12,
	parameter bit enable_bursts = 1'b1
) (
	input logic clk,
	input logic arst_n,
	input logic [7:0] idata,
	input logic raw_s,
	output logic [7:0] odata
);

	cmd_word_t word;
	logic word_tick;
	logic [7:0] pdata;

	// one local bus shared by the sequencer, the bank and the reply side
	local_bus_if bus ();

	// byte assembly, header skip and the echo delay
	packet_framer #(
		.read_pipe_len(read_pipe_len)
	) u_framer (
		.clk(clk),
		.arst_n(arst_n),
		.idata(idata),
		.raw_s(raw_s),
		.word(word),
		.word_tick(word_tick),
		.pdata(pdata)
	);

	bus_sequencer #(
		.read_pipe_len(read_pipe_len),
		.enable_bursts(enable_bursts)
	) u_seq (
		.clk(clk),
		.arst_n(arst_n),
		.word(word),
		.word_tick(word_tick),
		.raw_s(raw_s),
		.bus(bus.master)
	);

	// reply side puts read data back into the echoed stream
	reply_merger #(
		.read_pipe_len(read_pipe_len),
		.n_lat(n_lat)
	) u_merge (
		.clk(clk),
		.arst_n(arst_n),
		.pdata(pdata),
		.bus(bus.capture),
		.odata(odata)
	);

	reg_bank #(
		.read_pipe_len(read_pipe_len)
	) u_bank (
		.clk(clk),
		.arst_n(arst_n),
		.bus(bus.target)
	);

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int period = 40,
	parameter int rst_cycles = 3
) (
	output logic clk,
	output logic arst_n
);

	// free running clock, the testbench ends the run itself
	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	// reset is released on a falling edge so the first active edge sees a clean level
	initial begin
		arst_n = 1'b0;
		repeat (rst_cycles) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;
	end

endmodule

// File: tests/mem_gate_chk.sv
`timescale 1ns/1ps

module mem_gate_chk #(
	parameter int read_pipe_len = 3
) (
	input logic clk,
	input logic arst_n,
	input logic strobe,
	input logic rd,
	input logic write,
	input logic rd_valid
);

	// a write is only a qualified form of the strobe
	a_write_with_strobe: assert property (@(posedge clk) disable iff (!arst_n)
		write |-> strobe)
		else $error("write seen without strobe");

	// every read strobe is answered after the fixed read latency
	a_read_answered: assert property (@(posedge clk) disable iff (!arst_n)
		(strobe && rd) |-> ##read_pipe_len rd_valid)
		else $error("rd_valid missing after read strobe");

	// and rd_valid never shows up without a read behind it
	a_valid_has_read: assert property (@(posedge clk) disable iff (!arst_n)
		rd_valid |-> $past(strobe && rd, read_pipe_len))
		else $error("rd_valid without a matching read strobe");

	// words are four bytes apart, so strobes can never touch
	a_strobe_spacing: assert property (@(posedge clk) disable iff (!arst_n)
		strobe |=> !strobe)
		else $error("strobe on two consecutive cycles");

endmodule

// File: tests/mem_gate_tb.sv
`timescale 1ns/1ps

module mem_gate_tb;

	localparam int n_lat = 12;
	localparam int gap_len = 8;
	localparam int max_rows = 32;
	// flag bits of a command word as the packet format defines them
	localparam logic [31:0] rd_flag = 32'h1000_0000;
	localparam logic [31:0] rep_flag = 32'h2000_0000;

	logic clk;
	logic arst_n;
	logic [7:0] idata;
	logic raw_s;
	logic [7:0] odata;

	// transaction table, one row per bus operation or burst
	string row_name [$];
	bit row_rd [$];
	logic [23:0] row_addr [$];
	int row_cnt [$];
	logic [31:0] row_data [$];
	bit row_last [$];
	int row_cut [$];

	// byte stream with its expected echo and the row that owns each byte
	logic [7:0] stim_b [$];
	bit stim_s [$];
	logic [7:0] exp_b [$];
	int owner [$];

	logic [31:0] ref_mem [16];
	logic [31:0] rng;
	int n_chk [max_rows];
	int n_err [max_rows];
	int last_of [max_rows];

	tb_clock #(.period(40), .rst_cycles(3)) u_clk (.clk(clk), .arst_n(arst_n));

	mem_gate_top #(
		.read_pipe_len(3),
		.n_lat(n_lat),
		.enable_bursts(1'b1)
	) dut (
		.clk(clk),
		.arst_n(arst_n),
		.idata(idata),
		.raw_s(raw_s),
		.odata(odata)
	);

	bind mem_gate_top mem_gate_chk #(.read_pipe_len(read_pipe_len)) u_chk (
		.clk(clk),
		.arst_n(arst_n),
		.strobe(bus.strobe),
		.rd(bus.rd),
		.write(bus.write),
		.rd_valid(bus.rd_valid)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// data 0 asks for a random word, cut > 0 ends the packet inside the first data word
	task automatic add_row(input string name, input bit rd, input logic [23:0] addr,
		input int cnt, input logic [31:0] data, input bit last, input int cut);
		row_name.push_back(name);
		row_rd.push_back(rd);
		row_addr.push_back(addr);
		row_cnt.push_back(cnt);
		row_data.push_back(data);
		row_last.push_back(last);
		row_cut.push_back(cut);
	endtask

	// bytes go out in network order, most significant first
	task automatic push_word(input logic [31:0] w, input logic [31:0] e, input int t,
		input int nbytes);
		for (int k = 0; k < nbytes; k++) begin
			stim_b.push_back(w[31-8*k -: 8]);
			stim_s.push_back(1'b1);
			exp_b.push_back(e[31-8*k -: 8]);
			owner.push_back(t);
		end
	endtask

	// idle bytes are zero and come back as zero
	task automatic push_idle(input int n, input int t);
		for (int k = 0; k < n; k++) begin
			stim_b.push_back(8'h00);
			stim_s.push_back(1'b0);
			exp_b.push_back(8'h00);
			owner.push_back(t);
		end
	endtask

	// turns the table into packets and runs the reference memory alongside
	task automatic build_stream();
		logic [31:0] d;
		logic [31:0] cmd;
		logic [3:0] idx;
		int pkt;
		bit in_pkt;
		pkt = 0;
		in_pkt = 1'b0;
		for (int a = 0; a < 16; a++)
			ref_mem[a] = '0;
		push_idle(4, 0);
		for (int r = 0; r < row_name.size(); r++) begin
			if (!in_pkt) begin
				// sequence number then nonce, both echoed untouched
				pkt++;
				push_word(32'(pkt), 32'(pkt), r, 4);
				rng = xorshift(rng);
				push_word(rng, rng, r, 4);
				in_pkt = 1'b1;
			end
			if (row_cnt[r] > 1)
				push_word(rep_flag | 32'(row_cnt[r]), rep_flag | 32'(row_cnt[r]), r, 4);
			cmd = {8'h00, row_addr[r]} | (row_rd[r] ? rd_flag : 32'h0);
			push_word(cmd, cmd, r, 4);
			for (int i = 0; i < row_cnt[r]; i++) begin
				// only the low four address bits pick a register
				idx = row_addr[r][3:0] + 4'(i);
				if (row_data[r] == '0) begin
					rng = xorshift(rng);
					d = rng;
				end else begin
					d = row_data[r] + 32'(i);
				end
				if (row_cut[r] > 0) begin
					push_word(d, d, r, row_cut[r]);
					break;
				end else if (row_rd[r]) begin
					push_word(d, ref_mem[idx], r, 4);
				end else begin
					push_word(d, d, r, 4);
					ref_mem[idx] = d;
				end
			end
			if (row_last[r] || row_cut[r] > 0) begin
				push_idle(gap_len, (r + 1 < row_name.size()) ? r + 1 : r);
				in_pkt = 1'b0;
			end
		end
	endtask

	task automatic check_byte(input int j);
		int t;
		t = owner[j];
		n_chk[t]++;
		if (odata !== exp_b[j]) begin
			$display("** Error %s: byte %0d expected %02h actual %02h",
				row_name[t], j, exp_b[j], odata);
			n_err[t]++;
		end
		if (j == last_of[t])
			$display("%-16s %0d bytes checked, %0d mismatches", row_name[t], n_chk[t], n_err[t]);
	endtask

	initial begin
		int n;
		int wait_cnt;
		int total_chk;
		int total_err;
		idata = 8'h00;
		raw_s = 1'b0;
		rng = 32'h5699;
		total_chk = 0;
		total_err = 0;
		for (int t = 0; t < max_rows; t++) begin
			n_chk[t] = 0;
			n_err[t] = 0;
			last_of[t] = -1;
		end

		// name, rd, addr, count, data, last, cut
		add_row("reset_read", 1'b1, 24'h00000C, 1, 32'h0, 1'b0, 0);
		add_row("write_echo_a", 1'b0, 24'h000001, 1, 32'hCAFE_0001, 1'b0, 0);
		add_row("write_echo_b", 1'b0, 24'h000005, 1, 32'h0, 1'b1, 0);
		add_row("write_read", 1'b1, 24'h000001, 1, 32'h0, 1'b0, 0);
		add_row("burst_write", 1'b0, 24'h000008, 4, 32'h0, 1'b1, 0);
		add_row("burst_read", 1'b1, 24'h000008, 4, 32'h0, 1'b0, 0);
		add_row("alias_read", 1'b1, 24'h3A0015, 1, 32'h0, 1'b0, 0);
		add_row("truncated_write", 1'b0, 24'h000007, 1, 32'h7777_7777, 1'b0, 2);
		add_row("after_cut_read", 1'b1, 24'h000007, 1, 32'h0, 1'b0, 0);
		add_row("after_cut_write", 1'b0, 24'h00000E, 1, 32'h0, 1'b0, 0);
		add_row("after_cut_check", 1'b1, 24'h10000E, 1, 32'h0, 1'b1, 0);

		build_stream();
		n = stim_b.size();
		for (int j = 0; j < n; j++)
			last_of[owner[j]] = j;

		wait_cnt = 0;
		while (arst_n !== 1'b1 && wait_cnt < 20) begin
			@(posedge clk);
			wait_cnt++;
		end
		if (arst_n !== 1'b1) begin
			$display("reset was never released, no bytes were sent");
			total_err++;
		end else begin
			@(negedge clk);
			total_chk++;
			if (odata !== 8'h00) begin
				$display("** Error reset_odata: expected 00 actual %02h", odata);
				total_err++;
			end
			$display("%-16s 1 bytes checked, %0d mismatches", "reset_odata", total_err);
			// drive on the rising edge, compare each byte n_lat cycles later
			for (int i = 0; i < n + n_lat; i++) begin
				@(posedge clk);
				if (i < n) begin
					idata <= stim_b[i];
					raw_s <= stim_s[i];
				end else begin
					idata <= 8'h00;
					raw_s <= 1'b0;
				end
				@(negedge clk);
				if (i >= n_lat)
					check_byte(i - n_lat);
			end
		end

		for (int t = 0; t < row_name.size(); t++) begin
			total_chk += n_chk[t];
			total_err += n_err[t];
		end
		$display("checks: %0d, errors: %0d", total_chk, total_err);
		if (total_err == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

// File: project.f
logic/mem_gate_pkg.sv
logic/local_bus_if.sv
logic/packet_framer.sv
logic/bus_sequencer.sv
logic/reply_merger.sv
logic/reg_bank.sv
logic/mem_gate_top.sv
tests/tb_clock.sv
tests/mem_gate_chk.sv
tests/mem_gate_tb.sv

// File: Makefile
TOP = mem_gate_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert -j 0 --top-module $(TOP) -f project.f -o sim

run: build
	./obj_dir/sim > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "test failed" sim.log; then \
		echo "simulation failed, see sim.log"; exit 1; \
	fi

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir sim.log
